//--- hw/fetchPkg.sv
`default_nettype none

package fetchPkg;

    // byte address
    typedef logic [31:0] pcT;

    // sequence number of a fetch block, wraps around
    typedef logic [3:0] fetchIdT;

    // word index inside a 16-byte block
    typedef logic [1:0] blockOffT;

    typedef logic [31:0] instrT;

    typedef enum logic {
        faultNone,
        faultAccess
    } fetchFaultT;

    // legal window is [LEGAL_BASE, LEGAL_LIMIT)
    localparam pcT LEGAL_BASE = 32'h0000_0000;
    localparam pcT LEGAL_LIMIT = 32'h0001_0000;

endpackage

`default_nettype wire

//--- hw/icachePkg.sv
`default_nettype none

package icachePkg;

    localparam int LINE_BYTES = 16;
    localparam int NUM_SETS = 16;

    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - OFFSET_BITS - SET_BITS;

    // pc bits 7:4
    typedef logic [SET_BITS-1:0] setIdxT;

    // pc bits 31:8
    typedef logic [TAG_BITS-1:0] tagT;

    // four words, word 0 in the low bits
    typedef logic [LINE_BYTES*8-1:0] lineT;

    typedef enum logic [1:0] {
        flushIdle,
        flushQueued,
        flushActive
    } flushStateT;

endpackage

`default_nettype wire

//--- hw/icacheArray.sv
`default_nettype none

module icacheArray #(
    parameter int NUM_WAYS = 2,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input wire clk,
    input wire rst,

    input wire readEn,
    input wire icachePkg::setIdxT readIdx,

    input wire writeEn,
    input wire [WAY_BITS-1:0] writeWay,
    input wire icachePkg::setIdxT writeIdx,
    input wire icachePkg::tagT writeTag,
    input wire writeValid,
    input wire icachePkg::lineT writeLine,

    output icachePkg::tagT readTags [NUM_WAYS],
    output logic [NUM_WAYS-1:0] readValids,
    output icachePkg::lineT readLines [NUM_WAYS]
);

    logic validMem [NUM_WAYS][icachePkg::NUM_SETS];
    icachePkg::tagT tagMem [NUM_WAYS][icachePkg::NUM_SETS];
    icachePkg::lineT lineMem [NUM_WAYS][icachePkg::NUM_SETS];

    // one way of one set per write
    always_ff @(posedge clk) begin
        if (writeEn) begin
            validMem[writeWay][writeIdx] <= writeValid;
            tagMem[writeWay][writeIdx] <= writeTag;
            lineMem[writeWay][writeIdx] <= writeLine;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValids <= '0;
        end else if (readEn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                readValids[w] <= validMem[w][readIdx];
            end
        end
    end

    // all ways of the set come back together
    always_ff @(posedge clk) begin
        if (readEn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                readTags[w] <= tagMem[w][readIdx];
                readLines[w] <= lineMem[w][readIdx];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetchPipeline.sv
`default_nettype none

module fetchPipeline #(
    parameter int NUM_WAYS = 2,
    parameter int QUEUE_DEPTH = 4,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
    localparam int FREE_BITS = $clog2(QUEUE_DEPTH + 1)
) (
    input wire clk,
    input wire rst,
    input wire fetchValid,
    input wire fetchPkg::pcT fetchPc,
    input wire redirect,
    input wire fetchPkg::fetchIdT redirectId,
    input wire clearCache,
    input wire refillValid,
    input wire icachePkg::lineT refillData,
    input wire icachePkg::tagT readTags [NUM_WAYS],
    input wire [NUM_WAYS-1:0] readValids,
    input wire icachePkg::lineT readLines [NUM_WAYS],
    input wire [FREE_BITS-1:0] queueFree,

    output logic stall,
    output logic refetchValid,
    output fetchPkg::pcT refetchPc,
    output logic missReq,
    output fetchPkg::pcT missAddr,
    output logic readEn,
    output icachePkg::setIdxT readIdx,
    output logic writeEn,
    output logic [WAY_BITS-1:0] writeWay,
    output icachePkg::setIdxT writeIdx,
    output icachePkg::tagT writeTag,
    output logic writeValid,
    output icachePkg::lineT writeLine,
    output logic pushValid,
    output fetchPkg::pcT pushPc,
    output fetchPkg::fetchIdT pushId,
    output fetchPkg::blockOffT pushOff,
    output fetchPkg::fetchFaultT pushFault,
    output icachePkg::lineT pushLine
);

    logic s0Valid;
    fetchPkg::pcT s0Pc;
    logic s1Valid;
    fetchPkg::pcT s1Pc;
    fetchPkg::fetchIdT s1Id;
    fetchPkg::fetchIdT nextId;

    logic missPending;
    fetchPkg::pcT missLinePc;
    logic [WAY_BITS-1:0] rrWay;

    icachePkg::flushStateT flushState;
    logic [WAY_BITS-1:0] flushWay;
    icachePkg::setIdxT flushSet;

    logic accept;
    logic s1Legal;
    logic missNow;
    logic [NUM_WAYS-1:0] hitVec;
    icachePkg::lineT hitLine;

    // packets already in flight need a slot too
    always_comb begin
        stall = 1'b0;
        if (flushState != icachePkg::flushIdle)
            stall = 1'b1;
        if (missPending)
            stall = 1'b1;
        if (int'(queueFree) - int'(s0Valid) - int'(s1Valid) < 1)
            stall = 1'b1;
    end

    assign accept = fetchValid && !stall;

    // tags are read as the pc moves from stage 0 to stage 1
    assign readEn = s0Valid;
    assign readIdx = s0Pc[7:4];

    always_comb begin
        hitVec = '0;
        hitLine = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (readValids[w] && readTags[w] == s1Pc[31:8]) begin
                hitVec[w] = 1'b1;
                hitLine = hitLine | readLines[w];
            end
        end
    end

    assign s1Legal = (s1Pc >= fetchPkg::LEGAL_BASE) && (s1Pc < fetchPkg::LEGAL_LIMIT);
    assign missNow = s1Valid && s1Legal && (hitVec == '0) && !redirect;

    // illegal pc bypasses the tags entirely
    assign pushValid = s1Valid && !redirect && (!s1Legal || hitVec != '0);
    assign pushPc = s1Pc;
    assign pushId = s1Id;
    assign pushOff = s1Pc[3:2];
    assign pushFault = s1Legal ? fetchPkg::faultNone : fetchPkg::faultAccess;
    assign pushLine = s1Legal ? hitLine : '0;

    assign missReq = missNow;
    assign missAddr = {s1Pc[31:4], 4'b0000};
    assign refetchValid = missNow;
    assign refetchPc = s1Pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            nextId <= '0;
        end else if (redirect) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            nextId <= redirectId + 4'd1;
        end else if (missNow) begin
            // missed block keeps its id on the refetch
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            nextId <= s1Id;
        end else begin
            s0Valid <= accept;
            s1Valid <= s0Valid;
            if (s0Valid)
                nextId <= nextId + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            s0Pc <= fetchPc;
        if (s0Valid) begin
            s1Pc <= s0Pc;
            s1Id <= nextId;
        end
        if (missNow)
            missLinePc <= {s1Pc[31:4], 4'b0000};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            missPending <= 1'b0;
            rrWay <= '0;
        end else begin
            if (missNow)
                missPending <= 1'b1;
            else if (refillValid)
                missPending <= 1'b0;
            if (refillValid)
                rrWay <= (rrWay == WAY_BITS'(NUM_WAYS - 1)) ? '0 : rrWay + 1'b1;
        end
    end

    // flush walk owns the write port while active
    always_comb begin
        writeEn = refillValid;
        writeWay = rrWay;
        writeIdx = missLinePc[7:4];
        writeTag = missLinePc[31:8];
        writeValid = 1'b1;
        writeLine = refillData;
        if (flushState == icachePkg::flushActive) begin
            writeEn = 1'b1;
            writeWay = flushWay;
            writeIdx = flushSet;
            writeTag = '0;
            writeValid = 1'b0;
            writeLine = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flushState <= icachePkg::flushQueued;
            flushWay <= '0;
            flushSet <= '0;
        end else begin
            case (flushState)
                icachePkg::flushIdle: begin
                    if (clearCache)
                        flushState <= icachePkg::flushQueued;
                end
                icachePkg::flushQueued: begin
                    flushWay <= '0;
                    flushSet <= '0;
                    if (!s0Valid && !s1Valid && !missPending)
                        flushState <= icachePkg::flushActive;
                end
                icachePkg::flushActive: begin
                    if (flushSet == icachePkg::setIdxT'(icachePkg::NUM_SETS - 1)) begin
                        flushSet <= '0;
                        flushWay <= flushWay + 1'b1;
                        if (flushWay == WAY_BITS'(NUM_WAYS - 1))
                            flushState <= icachePkg::flushIdle;
                    end else begin
                        flushSet <= flushSet + 1'b1;
                    end
                end
                default: flushState <= icachePkg::flushIdle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) s1Valid |-> $onehot0(hitVec))
        else $error("fetchPipeline: tag hit in more than one way");

    // refill data only ever answers an earlier miss request
    assert property (@(posedge clk) disable iff (rst) refillValid |-> missPending)
        else $error("fetchPipeline: refill without outstanding miss");

endmodule

`default_nettype wire

//--- hw/fetchQueue.sv
`default_nettype none

module fetchQueue #(
    parameter int QUEUE_DEPTH = 4,
    localparam int FREE_BITS = $clog2(QUEUE_DEPTH + 1),
    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
    input wire clk,
    input wire rst,
    input wire clear,

    input wire pushValid,
    input wire fetchPkg::pcT pushPc,
    input wire fetchPkg::fetchIdT pushId,
    input wire fetchPkg::blockOffT pushOff,
    input wire fetchPkg::fetchFaultT pushFault,
    input wire icachePkg::lineT pushLine,

    input wire popReady,
    output logic popValid,
    output fetchPkg::pcT popPc,
    output fetchPkg::fetchIdT popId,
    output fetchPkg::blockOffT popOff,
    output fetchPkg::fetchFaultT popFault,
    output icachePkg::lineT popLine,

    output logic [FREE_BITS-1:0] free
);

    fetchPkg::pcT pcMem [QUEUE_DEPTH];
    fetchPkg::fetchIdT idMem [QUEUE_DEPTH];
    fetchPkg::blockOffT offMem [QUEUE_DEPTH];
    fetchPkg::fetchFaultT faultMem [QUEUE_DEPTH];
    icachePkg::lineT lineMem [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS-1:0] wrPtr;
    logic [FREE_BITS-1:0] count;
    logic pop;

    function automatic logic [PTR_BITS-1:0] bump(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = popValid && popReady;
    assign popValid = (count != '0);
    assign free = FREE_BITS'(QUEUE_DEPTH) - count;

    assign popPc = pcMem[rdPtr];
    assign popId = idMem[rdPtr];
    assign popOff = offMem[rdPtr];
    assign popFault = faultMem[rdPtr];
    assign popLine = lineMem[rdPtr];

    always_ff @(posedge clk) begin
        if (pushValid) begin
            pcMem[wrPtr] <= pushPc;
            idMem[wrPtr] <= pushId;
            offMem[wrPtr] <= pushOff;
            faultMem[wrPtr] <= pushFault;
            lineMem[wrPtr] <= pushLine;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid)
                wrPtr <= bump(wrPtr);
            if (pop)
                rdPtr <= bump(rdPtr);
            count <= count + FREE_BITS'(pushValid) - FREE_BITS'(pop);
        end
    end

    // the producer stalls on the free count, so this should never fire
    assert property (@(posedge clk) disable iff (rst) pushValid |-> free != '0)
        else $error("fetchQueue: push into full queue");

endmodule

`default_nettype wire

//--- hw/instrSplitter.sv
`default_nettype none

module instrSplitter (
    input wire clk,
    input wire rst,
    input wire clear,

    input wire popValid,
    input wire fetchPkg::pcT popPc,
    input wire fetchPkg::fetchIdT popId,
    input wire fetchPkg::blockOffT popOff,
    input wire fetchPkg::fetchFaultT popFault,
    input wire icachePkg::lineT popLine,
    output logic popReady,

    input wire instrReady,
    output logic instrValid,
    output fetchPkg::pcT instrPc,
    output fetchPkg::instrT instrWord,
    output fetchPkg::fetchFaultT instrFault,
    output fetchPkg::fetchIdT instrFetchId
);

    logic midPacket;
    fetchPkg::blockOffT wordIdx;
    fetchPkg::blockOffT curIdx;
    logic lastWord;
    logic take;

    // first word of a packet comes from its offset
    assign curIdx = midPacket ? wordIdx : popOff;
    assign lastWord = (curIdx == 2'd3) || (popFault == fetchPkg::faultAccess);
    assign take = popValid && instrReady;

    assign instrValid = popValid;
    assign instrPc = {popPc[31:4], curIdx, 2'b00};
    assign instrWord = popLine[curIdx*32 +: 32];
    assign instrFault = popFault;
    assign instrFetchId = popId;

    assign popReady = take && lastWord;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            midPacket <= 1'b0;
            wordIdx <= '0;
        end else if (take) begin
            if (lastWord) begin
                midPacket <= 1'b0;
            end else begin
                midPacket <= 1'b1;
                wordIdx <= curIdx + 2'd1;
            end
        end
    end

    // a waiting instruction must not change under the consumer
    assert property (@(posedge clk) disable iff (rst || clear)
        instrValid && !instrReady |=> instrValid && $stable(instrPc) && $stable(instrFetchId))
        else $error("instrSplitter: instruction changed while not accepted");

endmodule

`default_nettype wire

//--- hw/fetchUnit.sv
`default_nettype none

module fetchUnit #(
    parameter int NUM_WAYS = 2,
    parameter int QUEUE_DEPTH = 4,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
    localparam int FREE_BITS = $clog2(QUEUE_DEPTH + 1)
) (
    input wire clk,
    input wire rst,
    input wire fetchValid,
    input wire fetchPkg::pcT fetchPc,
    input wire redirect,
    input wire fetchPkg::fetchIdT redirectId,
    input wire clearCache,
    input wire refillValid,
    input wire icachePkg::lineT refillData,
    input wire instrReady,

    output logic stall,
    output logic refetchValid,
    output fetchPkg::pcT refetchPc,
    output logic missReq,
    output fetchPkg::pcT missAddr,
    output logic instrValid,
    output fetchPkg::pcT instrPc,
    output fetchPkg::instrT instrWord,
    output fetchPkg::fetchFaultT instrFault,
    output fetchPkg::fetchIdT instrFetchId
);

    logic readEn;
    icachePkg::setIdxT readIdx;
    icachePkg::tagT readTags [NUM_WAYS];
    logic [NUM_WAYS-1:0] readValids;
    icachePkg::lineT readLines [NUM_WAYS];

    logic writeEn;
    logic [WAY_BITS-1:0] writeWay;
    icachePkg::setIdxT writeIdx;
    icachePkg::tagT writeTag;
    logic writeValid;
    icachePkg::lineT writeLine;

    logic pushValid;
    fetchPkg::pcT pushPc;
    fetchPkg::fetchIdT pushId;
    fetchPkg::blockOffT pushOff;
    fetchPkg::fetchFaultT pushFault;
    icachePkg::lineT pushLine;
    logic [FREE_BITS-1:0] queueFree;

    logic popValid;
    logic popReady;
    fetchPkg::pcT popPc;
    fetchPkg::fetchIdT popId;
    fetchPkg::blockOffT popOff;
    fetchPkg::fetchFaultT popFault;
    icachePkg::lineT popLine;

    icacheArray #(
        .NUM_WAYS(NUM_WAYS)
    ) u_icacheArray (
        .clk(clk),
        .rst(rst),
        .readEn(readEn),
        .readIdx(readIdx),
        .writeEn(writeEn),
        .writeWay(writeWay),
        .writeIdx(writeIdx),
        .writeTag(writeTag),
        .writeValid(writeValid),
        .writeLine(writeLine),
        .readTags(readTags),
        .readValids(readValids),
        .readLines(readLines)
    );

    fetchPipeline #(
        .NUM_WAYS(NUM_WAYS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetchPipeline (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .redirect(redirect),
        .redirectId(redirectId),
        .clearCache(clearCache),
        .refillValid(refillValid),
        .refillData(refillData),
        .readTags(readTags),
        .readValids(readValids),
        .readLines(readLines),
        .queueFree(queueFree),
        .stall(stall),
        .refetchValid(refetchValid),
        .refetchPc(refetchPc),
        .missReq(missReq),
        .missAddr(missAddr),
        .readEn(readEn),
        .readIdx(readIdx),
        .writeEn(writeEn),
        .writeWay(writeWay),
        .writeIdx(writeIdx),
        .writeTag(writeTag),
        .writeValid(writeValid),
        .writeLine(writeLine),
        .pushValid(pushValid),
        .pushPc(pushPc),
        .pushId(pushId),
        .pushOff(pushOff),
        .pushFault(pushFault),
        .pushLine(pushLine)
    );

    // a redirect drops everything already buffered
    fetchQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetchQueue (
        .clk(clk),
        .rst(rst),
        .clear(redirect),
        .pushValid(pushValid),
        .pushPc(pushPc),
        .pushId(pushId),
        .pushOff(pushOff),
        .pushFault(pushFault),
        .pushLine(pushLine),
        .popReady(popReady),
        .popValid(popValid),
        .popPc(popPc),
        .popId(popId),
        .popOff(popOff),
        .popFault(popFault),
        .popLine(popLine),
        .free(queueFree)
    );

    instrSplitter u_instrSplitter (
        .clk(clk),
        .rst(rst),
        .clear(redirect),
        .popValid(popValid),
        .popPc(popPc),
        .popId(popId),
        .popOff(popOff),
        .popFault(popFault),
        .popLine(popLine),
        .popReady(popReady),
        .instrReady(instrReady),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .instrWord(instrWord),
        .instrFault(instrFault),
        .instrFetchId(instrFetchId)
    );

endmodule

`default_nettype wire

//--- tb/tbRefillMemory.sv
`default_nettype none

module tbRefillMemory (
    input wire clk,
    input wire rst,
    input wire missReq,
    input wire fetchPkg::pcT missAddr,
    input wire [2:0] delayPick,
    output logic refillValid,
    output icachePkg::lineT refillData
);

    logic busy = 1'b0;
    logic [2:0] waitLeft = 3'd0;
    fetchPkg::pcT lineAddr = '0;
    logic validReg = 1'b0;
    icachePkg::lineT dataReg = '0;

    assign refillValid = validReg;
    assign refillData = dataReg;

    // word at address A is A xor 5A5A_0000
    function automatic icachePkg::lineT lineAt(input fetchPkg::pcT base);
        icachePkg::lineT line;
        line = '0;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = (base + 32'(i * 4)) ^ 32'h5A5A_0000;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            validReg <= 1'b0;
        end else begin
            validReg <= 1'b0;
            if (missReq) begin
                busy <= 1'b1;
                lineAddr <= missAddr;
                waitLeft <= delayPick;
            end else if (busy) begin
                if (waitLeft == 3'd0) begin
                    validReg <= 1'b1;
                    dataReg <= lineAt(lineAddr);
                    busy <= 1'b0;
                end else begin
                    waitLeft <= waitLeft - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tbFetchUnit.sv
`default_nettype none

module tbFetchUnit;

    // six short tests, each well under 400 cycles, plus the reset flush
    localparam int MAX_CYCLES = 4000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic fetchValid = 1'b0;
    fetchPkg::pcT fetchPc = 32'h0000_0104;
    logic redirect = 1'b0;
    fetchPkg::fetchIdT redirectId = 4'd0;
    logic clearCache = 1'b0;
    logic refillValid;
    icachePkg::lineT refillData;
    logic instrReady = 1'b0;

    logic stall;
    logic refetchValid;
    fetchPkg::pcT refetchPc;
    logic missReq;
    fetchPkg::pcT missAddr;
    logic instrValid;
    fetchPkg::pcT instrPc;
    fetchPkg::instrT instrWord;
    fetchPkg::fetchFaultT instrFault;
    fetchPkg::fetchIdT instrFetchId;

    logic prodOn = 1'b0;
    fetchPkg::pcT redirectTarget = '0;
    logic [1:0] readyMode = 2'd0;
    logic [31:0] lfsr = 32'h585a54ac;
    logic [2:0] delayPick = 3'd0;

    // pc offered one and two cycles ago, the stage 1 pc on a miss
    fetchPkg::pcT issuedPc [2];

    // expected next instruction
    fetchPkg::fetchIdT expId = 4'd0;
    logic [27:0] expBase = 28'h10;
    logic [1:0] expOff = 2'd1;

    logic watchMiss = 1'b1;
    fetchPkg::pcT watchPc = 32'h0000_0104;
    logic refillOwed = 1'b0;
    int takenCount = 0;
    int missCount = 0;
    int hundredCount = 0;
    int cycles = 0;
    int errorCount = 0;

    always #2 clk = ~clk;

    fetchUnit #(
        .NUM_WAYS(2),
        .QUEUE_DEPTH(4)
    ) u_fetchUnit (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .redirect(redirect),
        .redirectId(redirectId),
        .clearCache(clearCache),
        .refillValid(refillValid),
        .refillData(refillData),
        .instrReady(instrReady),
        .stall(stall),
        .refetchValid(refetchValid),
        .refetchPc(refetchPc),
        .missReq(missReq),
        .missAddr(missAddr),
        .instrValid(instrValid),
        .instrPc(instrPc),
        .instrWord(instrWord),
        .instrFault(instrFault),
        .instrFetchId(instrFetchId)
    );

    tbRefillMemory u_refillMemory (
        .clk(clk),
        .rst(rst),
        .missReq(missReq),
        .missAddr(missAddr),
        .delayPick(delayPick),
        .refillValid(refillValid),
        .refillData(refillData)
    );

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one bit for instrReady, three for the refill delay
    always @(posedge clk) begin
        logic [31:0] s;
        logic [2:0] pick;
        s = lfsr;
        instrReady <= (readyMode == 2'd0) || (readyMode == 2'd1 && s[0]);
        s = stepLfsr(s);
        for (int i = 0; i < 3; i++) begin
            pick[i] = s[0];
            s = stepLfsr(s);
        end
        delayPick <= pick;
        lfsr <= s;
    end

    // pc producer: sequential blocks, restart on refetch or redirect
    always @(posedge clk) begin
        fetchValid <= prodOn;
        issuedPc[0] <= fetchPc;
        issuedPc[1] <= issuedPc[0];
        if (redirect)
            fetchPc <= redirectTarget;
        else if (refetchValid)
            fetchPc <= refetchPc;
        else if (fetchValid && !stall)
            fetchPc <= {fetchPc[31:4] + 28'd1, 4'h0};
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (missReq)
            missCount <= missCount + 1;
        if (missReq)
            refillOwed <= 1'b1;
        else if (refillValid)
            refillOwed <= 1'b0;
        if (instrValid && instrReady) begin
            takenCount <= takenCount + 1;
            if (instrPc == 32'h0000_0100)
                hundredCount <= hundredCount + 1;
        end
        if (redirect) begin
            expId <= redirectId + 4'd1;
            expBase <= redirectTarget[31:4];
            expOff <= redirectTarget[3:2];
        end else if (instrValid && instrReady) begin
            // a fault block gives one entry only
            if (expOff == 2'd3 || {expBase, 4'h0} >= fetchPkg::LEGAL_LIMIT) begin
                expId <= expId + 4'd1;
                expBase <= expBase + 28'd1;
                expOff <= 2'd0;
            end else begin
                expOff <= expOff + 2'd1;
            end
        end
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        missReq |-> missAddr == {issuedPc[1][31:4], 4'h0})
        else begin
            errorCount++;
            $display("ERROR missAddr: got %h expected %h", missAddr,
                {issuedPc[1][31:4], 4'h0});
        end

    assert property (@(posedge clk) disable iff (rst)
        missReq || refetchValid |-> missReq && refetchValid && refetchPc == issuedPc[1])
        else begin
            errorCount++;
            $display("ERROR refetchPc: got %h expected %h, missReq %h refetchValid %h",
                refetchPc, issuedPc[1], missReq, refetchValid);
        end

    assert property (@(posedge clk) disable iff (rst)
        missReq |-> issuedPc[1] < fetchPkg::LEGAL_LIMIT)
        else begin
            errorCount++;
            $display("a miss was raised for a pc outside the legal window");
        end

    assert property (@(posedge clk) disable iff (rst)
        missReq && watchMiss |-> refetchPc == watchPc)
        else begin
            errorCount++;
            $display("ERROR refetchPc: got %h expected %h", refetchPc, watchPc);
        end

    // stall holds while a refill is owed and through the reset flush
    assert property (@(posedge clk) disable iff (rst)
        refillOwed || $fell(rst) |-> stall)
        else begin
            errorCount++;
            $display("ERROR stall: got %h expected %h", stall, 1'b1);
        end

    assert property (@(posedge clk) disable iff (rst)
        instrValid && instrFault == fetchPkg::faultNone |->
            instrWord == (instrPc ^ 32'h5A5A_0000))
        else begin
            errorCount++;
            $display("ERROR instrWord: got %h expected %h", instrWord,
                instrPc ^ 32'h5A5A_0000);
        end

    assert property (@(posedge clk) disable iff (rst)
        instrValid |-> (instrFault == fetchPkg::faultAccess) ==
            (instrPc >= fetchPkg::LEGAL_LIMIT))
        else begin
            errorCount++;
            $display("ERROR instrFault: got %h for pc %h", instrFault, instrPc);
        end

    assert property (@(posedge clk) disable iff (rst)
        instrValid && instrFault == fetchPkg::faultAccess |-> instrWord == '0)
        else begin
            errorCount++;
            $display("ERROR instrWord: got %h expected %h", instrWord, 32'h0);
        end

    assert property (@(posedge clk) disable iff (rst)
        instrValid && instrReady |-> instrFetchId == expId)
        else begin
            errorCount++;
            $display("ERROR instrFetchId: got %h expected %h", instrFetchId, expId);
        end

    assert property (@(posedge clk) disable iff (rst)
        instrValid && instrReady |-> instrPc == {expBase, expOff, 2'b00})
        else begin
            errorCount++;
            $display("ERROR instrPc: got %h expected %h", instrPc, {expBase, expOff, 2'b00});
        end

    task automatic waitTaken(input int n);
        int target;
        target = takenCount + n;
        while (takenCount < target)
            @(posedge clk);
    endtask

    task automatic waitMiss();
        int target;
        target = missCount + 1;
        while (missCount < target)
            @(posedge clk);
    endtask

    task automatic jumpTo(input fetchPkg::pcT target, input fetchPkg::fetchIdT id);
        @(posedge clk);
        redirect <= 1'b1;
        redirectId <= id;
        redirectTarget <= target;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s finished, errors so far %0d", num, name, errorCount);
    endtask

    initial begin
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        prodOn <= 1'b1;

        waitMiss();
        @(posedge clk);
        watchMiss <= 1'b0;
        report(1, "first fetch misses");

        waitTaken(12);
        report(2, "refill data and pc order");

        jumpTo(32'h0001_0000, 4'd5);
        waitTaken(3);
        report(3, "illegal pc fault");

        jumpTo(32'h0000_0100, 4'd9);
        waitTaken(8);
        report(4, "redirect renumbers ids");

        readyMode <= 2'd2;
        do @(posedge clk); while (!stall);
        repeat (30) @(posedge clk);
        readyMode <= 2'd1;
        waitTaken(24);
        readyMode <= 2'd0;
        report(5, "backpressure");

        begin
            int seen;
            seen = hundredCount;
            jumpTo(32'h0000_0100, 4'd2);
            while (hundredCount == seen)
                @(posedge clk);
            prodOn <= 1'b0;
            @(posedge clk);
            clearCache <= 1'b1;
            @(posedge clk);
            clearCache <= 1'b0;
            do @(posedge clk); while (stall);
            watchPc <= 32'h0000_0100;
            watchMiss <= 1'b1;
            prodOn <= 1'b1;
            jumpTo(32'h0000_0100, 4'd7);
            waitMiss();
            @(posedge clk);
            watchMiss <= 1'b0;
            waitTaken(4);
        end
        report(6, "clear forces a miss");

        $display("done: %0d errors, %0d instructions, %0d misses",
            errorCount, takenCount, missCount);
        if (errorCount == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/fetchPkg.sv
hw/icachePkg.sv
hw/icacheArray.sv
hw/fetchPipeline.sv
hw/fetchQueue.sv
hw/instrSplitter.sv
hw/fetchUnit.sv
tb/tbRefillMemory.sv
tb/tbFetchUnit.sv

//--- Makefile
SOURCES := $(shell cat build.f)

obj_dir/VtbFetchUnit: build.f $(SOURCES)
	verilator --binary --assert -f build.f --top-module tbFetchUnit -o VtbFetchUnit

.PHONY: run clean

run: obj_dir/VtbFetchUnit
	./obj_dir/VtbFetchUnit | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
